/* common/spi_params.svh */
// SPI opcodes, chip identification byte, register count and synchronizer depth

`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// Opcode that answers with the identification byte
`define SPI_OP_CHIP_ID 8'hDB

// Burst write, first operand is the start address, then data bytes
`define SPI_OP_REG_WRITE 8'h20

// Burst read, first operand is the start address, then read bytes
`define SPI_OP_REG_READ 8'h21

// Identification byte returned by the chip ID opcode
`define SPI_CHIP_ID 8'h81

// Number of byte registers, a power of two so the pointer wraps cleanly
`define SPI_REG_COUNT 16

// Flops in each valid flag synchronizer
`define SPI_SYNC_STAGES 2

`endif

/* common/spi_pkg.sv */
// Shared types: data byte, register address, operand count, decoder states, register command

`include "spi_params.svh"

package spi_pkg;

    // One byte on the SPI bus
    typedef logic [7:0] byte_t;

    // Register address, wide enough for the whole bank
    typedef logic [$clog2(`SPI_REG_COUNT)-1:0] reg_addr_t;

    // Completed operand bytes in a transaction, saturates at all ones
    typedef logic [7:0] operand_count_t;

    // Command decoder states
    typedef enum logic [2:0] {
        IDLE,
        CHIP_ID,
        WRITE_ADDR,
        WRITE_DATA,
        READ_ADDR,
        READ_DATA,
        IGNORE
    } decoder_state_t;

    // Decoder to register bank
    // load_address with advance starts a read burst
    // load_address alone loads the pointer and ends any read burst
    typedef struct packed {
        logic      load_address;
        logic      write;
        logic      advance;
        reg_addr_t addr;
        byte_t     data;
    } reg_command_t;

endpackage

/* spi/spi_peripheral.sv */
// SPI target shift logic: bit counting, opcode and operand capture, response select, output shift

`timescale 1ns/1ps

module spi_peripheral (
    input  logic                    clock_in,
    input  logic                    local_reset_n,

    // External SPI pins, mode 0, active low select
    input  logic                    spi_select,
    input  logic                    spi_clock,
    input  logic                    spi_copi,
    output logic                    spi_cipo,

    // Received bytes and flags, all in the SPI clock domain
    output spi_pkg::byte_t          opcode,
    output spi_pkg::byte_t          operand,
    output logic                    opcode_valid,
    output logic                    operand_valid,
    output spi_pkg::operand_count_t operand_count,

    // Responders in the system clock domain
    input  spi_pkg::byte_t          response_1,
    input  logic                    response_1_valid,
    input  spi_pkg::byte_t          response_2,
    input  logic                    response_2_valid
);

    logic           spi_reset_n;
    logic           spi_local_clock;
    logic [3:0]     bit_index;
    logic [6:0]     shift_data;
    spi_pkg::byte_t response_byte;
    spi_pkg::byte_t response_select;

    // Select high holds the whole SPI side in reset
    always_comb spi_reset_n = local_reset_n & ~spi_select;

    // Clock parks high while deselected
    always_comb spi_local_clock = spi_clock | spi_select;

    // Bit counter and flags
    // Index runs 15 to 0 for opcode plus first operand, then 7 to 0 per operand
    always_ff @(posedge spi_local_clock or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            bit_index     <= 4'd15;
            opcode_valid  <= 1'b0;
            operand_valid <= 1'b0;
            operand_count <= '0;
        end else begin
            if (bit_index != 4'd0) begin
                bit_index <= bit_index - 4'd1;
            end else begin
                bit_index <= 4'd7;
            end

            // Opcode flag is a level until select rises
            if (bit_index == 4'd8) begin
                opcode_valid <= 1'b1;
            end

            // Operand flag lasts one SPI period
            operand_valid <= (bit_index == 4'd0);

            if (bit_index == 4'd0 && operand_count != '1) begin
                operand_count <= operand_count + 8'd1;
            end
        end
    end

    // Assemble in a shift register so a finished byte holds for a full byte time
    always_ff @(posedge spi_local_clock) begin
        shift_data <= {shift_data[5:0], spi_copi};

        if (bit_index == 4'd8) begin
            opcode <= {shift_data, spi_copi};
        end

        if (bit_index == 4'd0) begin
            operand <= {shift_data, spi_copi};
        end
    end

    // Exactly one responder may drive, anything else answers zero
    always_comb begin
        case ({response_1_valid, response_2_valid})
            2'b10:   response_byte = response_1;
            2'b01:   response_byte = response_2;
            default: response_byte = '0;
        endcase
    end

    // Registered in the system domain so the SPI side sees a clean byte
    always_ff @(posedge clock_in or negedge local_reset_n) begin
        if (!local_reset_n) begin
            response_select <= '0;
        end else begin
            response_select <= response_byte;
        end
    end

    // MSB first on falling edges, bit 7 leaves right after the previous byte
    always_ff @(negedge spi_local_clock or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            spi_cipo <= 1'b0;
        end else if (bit_index < 4'd8) begin
            spi_cipo <= response_select[bit_index[2:0]];
        end
    end

    // Decoder and register bank must never answer at the same time
    responders_exclusive: assert property (
        @(posedge clock_in) disable iff (!local_reset_n)
        !(response_1_valid && response_2_valid)
    );

endmodule

/* source/command_decoder.sv */
// Command decoder: valid flag synchronizers, edge strobes, opcode FSM, register commands

`timescale 1ns/1ps

`include "spi_params.svh"

module command_decoder (
    input  logic                  clock_in,
    input  logic                  local_reset_n,
    input  spi_pkg::byte_t        opcode,
    input  spi_pkg::byte_t        operand,
    input  logic                  opcode_valid,
    input  logic                  operand_valid,
    output spi_pkg::byte_t        response_1,
    output logic                  response_1_valid,
    output spi_pkg::reg_command_t reg_command
);

    logic [`SPI_SYNC_STAGES-1:0] opcode_sync;
    logic [`SPI_SYNC_STAGES-1:0] operand_sync;
    logic                        opcode_level;
    logic                        operand_level;
    logic                        opcode_level_q;
    logic                        operand_level_q;
    logic                        opcode_strobe;
    logic                        operand_strobe;
    spi_pkg::decoder_state_t     state;

    always_ff @(posedge clock_in or negedge local_reset_n) begin
        if (!local_reset_n) begin
            opcode_sync     <= '0;
            operand_sync    <= '0;
            opcode_level_q  <= 1'b0;
            operand_level_q <= 1'b0;
        end else begin
            opcode_sync     <= {opcode_sync[`SPI_SYNC_STAGES-2:0], opcode_valid};
            operand_sync    <= {operand_sync[`SPI_SYNC_STAGES-2:0], operand_valid};
            opcode_level_q  <= opcode_level;
            operand_level_q <= operand_level;
        end
    end

    always_comb begin
        opcode_level   = opcode_sync[`SPI_SYNC_STAGES-1];
        operand_level  = operand_sync[`SPI_SYNC_STAGES-1];
        opcode_strobe  = opcode_level & ~opcode_level_q;
        operand_strobe = operand_level & ~operand_level_q;
    end

    always_ff @(posedge clock_in or negedge local_reset_n) begin
        if (!local_reset_n) begin
            state       <= spi_pkg::IDLE;
            reg_command <= '0;
        end else begin
            reg_command.load_address <= 1'b0;
            reg_command.write        <= 1'b0;
            reg_command.advance      <= 1'b0;

            if (!opcode_level) begin
                // Select went high, a lone load_address closes a read burst
                if (state == spi_pkg::READ_ADDR || state == spi_pkg::READ_DATA) begin
                    reg_command.load_address <= 1'b1;
                end
                state <= spi_pkg::IDLE;
            end else if (opcode_strobe) begin
                case (opcode)
                    `SPI_OP_CHIP_ID:   state <= spi_pkg::CHIP_ID;
                    `SPI_OP_REG_WRITE: state <= spi_pkg::WRITE_ADDR;
                    `SPI_OP_REG_READ:  state <= spi_pkg::READ_ADDR;
                    default:           state <= spi_pkg::IGNORE;
                endcase
            end else if (operand_strobe) begin
                case (state)
                    spi_pkg::WRITE_ADDR: begin
                        reg_command.load_address <= 1'b1;
                        reg_command.addr         <= spi_pkg::reg_addr_t'(operand);
                        state                    <= spi_pkg::WRITE_DATA;
                    end
                    spi_pkg::WRITE_DATA: begin
                        reg_command.write <= 1'b1;
                        reg_command.data  <= operand;
                    end
                    spi_pkg::READ_ADDR: begin
                        reg_command.load_address <= 1'b1;
                        reg_command.advance      <= 1'b1;
                        reg_command.addr         <= spi_pkg::reg_addr_t'(operand);
                        state                    <= spi_pkg::READ_DATA;
                    end
                    spi_pkg::READ_DATA: reg_command.advance <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        response_1       = `SPI_CHIP_ID;
        response_1_valid = (state == spi_pkg::CHIP_ID);
    end

    // Opcode flag rises a full byte before any operand flag
    strobes_apart: assert property (
        @(posedge clock_in) disable iff (!local_reset_n)
        !(opcode_strobe && operand_strobe)
    );

endmodule

/* source/register_bank.sv */
// Register bank: byte register array, wrapping address pointer, burst write, registered read data

`timescale 1ns/1ps

`include "spi_params.svh"

module register_bank (
    input  logic                  clock_in,
    input  logic                  local_reset_n,
    input  spi_pkg::reg_command_t reg_command,
    output spi_pkg::byte_t        response_2,
    output logic                  response_2_valid
);

    spi_pkg::byte_t    registers [`SPI_REG_COUNT];
    spi_pkg::reg_addr_t pointer;
    spi_pkg::reg_addr_t pointer_next;

    // Load wins over increment, so a read burst starts at the given address
    always_comb begin
        pointer_next = pointer;
        if (reg_command.load_address) begin
            pointer_next = reg_command.addr;
        end else if (reg_command.write || reg_command.advance) begin
            pointer_next = pointer + spi_pkg::reg_addr_t'(1);
        end
    end

    always_ff @(posedge clock_in or negedge local_reset_n) begin
        if (!local_reset_n) begin
            pointer          <= '0;
            response_2_valid <= 1'b0;
        end else begin
            pointer <= pointer_next;

            // Load with advance opens a read burst, a plain load closes it
            if (reg_command.load_address) begin
                response_2_valid <= reg_command.advance;
            end
        end
    end

    always_ff @(posedge clock_in or negedge local_reset_n) begin
        if (!local_reset_n) begin
            for (int i = 0; i < `SPI_REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (reg_command.write) begin
            registers[pointer] <= reg_command.data;
        end
    end

    // Data for the next pointer, so it is ready one cycle after the command
    always_ff @(posedge clock_in) begin
        response_2 <= registers[pointer_next];
    end

    // One increment source per cycle
    write_or_advance: assert property (
        @(posedge clock_in) disable iff (!local_reset_n)
        !(reg_command.write && reg_command.advance)
    );

endmodule

/* source/spi_subsystem.sv */
// Top level: SPI peripheral, command decoder and register bank

`timescale 1ns/1ps

module spi_subsystem (
    input  logic clock_in,
    input  logic local_reset_n,
    input  logic spi_select,
    input  logic spi_clock,
    input  logic spi_copi,
    output logic spi_cipo
);

    spi_pkg::byte_t        opcode;
    spi_pkg::byte_t        operand;
    logic                  opcode_valid;
    logic                  operand_valid;
    spi_pkg::byte_t        response_1;
    logic                  response_1_valid;
    spi_pkg::byte_t        response_2;
    logic                  response_2_valid;
    spi_pkg::reg_command_t reg_command;

    // Operand count has no consumer in this subsystem
    spi_peripheral peripheral (
        .clock_in         (clock_in),
        .local_reset_n    (local_reset_n),
        .spi_select       (spi_select),
        .spi_clock        (spi_clock),
        .spi_copi         (spi_copi),
        .spi_cipo         (spi_cipo),
        .opcode           (opcode),
        .operand          (operand),
        .opcode_valid     (opcode_valid),
        .operand_valid    (operand_valid),
        .operand_count    (),
        .response_1       (response_1),
        .response_1_valid (response_1_valid),
        .response_2       (response_2),
        .response_2_valid (response_2_valid)
    );

    command_decoder decoder (
        .clock_in         (clock_in),
        .local_reset_n    (local_reset_n),
        .opcode           (opcode),
        .operand          (operand),
        .opcode_valid     (opcode_valid),
        .operand_valid    (operand_valid),
        .response_1       (response_1),
        .response_1_valid (response_1_valid),
        .reg_command      (reg_command)
    );

    register_bank bank (
        .clock_in         (clock_in),
        .local_reset_n    (local_reset_n),
        .reg_command      (reg_command),
        .response_2       (response_2),
        .response_2_valid (response_2_valid)
    );

endmodule

/* verification/spi_subsystem_tb.sv */
// Testbench for the SPI subsystem: clock, reset, SPI host, register model, checks and timeout

`timescale 1ns/1ps

`include "spi_params.svh"

module spi_subsystem_tb;

    // SPI half-period in clock_in cycles, idle gap with select high between transactions
    localparam int half_period_cycles = 12;
    localparam int gap_cycles         = 24;

    // About 40 transactions of up to 10 bytes at 192 cycles per byte, doubled
    localparam int timeout_cycles     = 150000;

    logic       clock_in;
    logic       local_reset_n;
    logic       spi_select;
    logic       spi_clock;
    logic       spi_copi;
    logic       spi_cipo;

    int         seed = 32'h2fbd4dae;
    int         cycle_count;
    int         error_count;
    int         errors_at_start;
    int         tests_passed;
    int         tests_failed;

    logic [7:0] tx_bytes [$];
    logic [7:0] rx_bytes [$];

    // Reference copy of the register bank
    logic [7:0] model_regs [`SPI_REG_COUNT];

    spi_subsystem DUT (
        .clock_in      (clock_in),
        .local_reset_n (local_reset_n),
        .spi_select    (spi_select),
        .spi_clock     (spi_clock),
        .spi_copi      (spi_copi),
        .spi_cipo      (spi_cipo)
    );

    initial begin
        clock_in = 1'b0;
        forever #20 clock_in = ~clock_in;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock_in);
            cycle_count++;
        end
        $display("Timeout: the tests did not complete within %0d clock cycles", timeout_cycles);
        $display("sim failed");
        $finish;
    end

    function automatic int random_below(input int limit);
        int value;
        value = $random(seed);
        return (value & 32'h7fff_ffff) % limit;
    endfunction

    // Addresses wrap modulo the register count
    function automatic logic [3:0] wrap_address(input int address);
        return 4'(address % `SPI_REG_COUNT);
    endfunction

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clock_in);
        #1;
    endtask

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic close_test(input string name);
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, error_count - errors_at_start);
        end
    endtask

    // Mode 0, MSB first, cipo sampled just before each rising edge
    task automatic shift_bits(input logic [7:0] tx, input int bit_count, output logic [7:0] rx);
        logic [7:0] shift;
        int         i;
        shift = tx;
        rx    = 8'h00;
        for (i = 0; i < bit_count; i++) begin
            spi_copi = shift[7];
            shift    = {shift[6:0], 1'b0};
            wait_cycles(half_period_cycles);
            rx        = {rx[6:0], spi_cipo};
            spi_clock = 1'b1;
            wait_cycles(half_period_cycles);
            spi_clock = 1'b0;
        end
    endtask

    // Sends tx_bytes, fills rx_bytes, optionally cut short by a partial byte
    task automatic run_transaction(input int partial_bits);
        logic [7:0] rx;
        int         k;
        rx_bytes.delete();
        wait_cycles(1);
        spi_select = 1'b0;
        for (k = 0; k < tx_bytes.size(); k++) begin
            shift_bits(tx_bytes[k], 8, rx);
            rx_bytes.push_back(rx);
        end
        if (partial_bits > 0) begin
            shift_bits(8'(random_below(256)), partial_bits, rx);
        end
        wait_cycles(half_period_cycles);
        spi_select = 1'b1;
        spi_copi   = 1'b0;
        // Output must stay low while deselected
        for (k = 0; k < gap_cycles; k++) begin
            wait_cycles(1);
            check_value("spi_cipo", {7'b0, spi_cipo}, 8'h00);
        end
    endtask

    task automatic read_and_compare(input int start, input int count);
        int k;
        tx_bytes.delete();
        tx_bytes.push_back(`SPI_OP_REG_READ);
        tx_bytes.push_back(8'(start));
        for (k = 0; k < count; k++) begin
            tx_bytes.push_back(8'(random_below(256)));
        end
        run_transaction(0);
        check_value("spi_cipo", rx_bytes[0], 8'h00);
        check_value("spi_cipo", rx_bytes[1], 8'h00);
        for (k = 0; k < count; k++) begin
            check_value("spi_cipo", rx_bytes[k + 2], model_regs[wrap_address(start + k)]);
        end
    endtask

    task automatic write_and_compare(input int start, input int count, input int partial_bits);
        logic [7:0] data;
        int         k;
        tx_bytes.delete();
        tx_bytes.push_back(`SPI_OP_REG_WRITE);
        tx_bytes.push_back(8'(start));
        for (k = 0; k < count; k++) begin
            data = 8'(random_below(256));
            tx_bytes.push_back(data);
            model_regs[wrap_address(start + k)] = data;
        end
        run_transaction(partial_bits);
        for (k = 0; k < rx_bytes.size(); k++) begin
            check_value("spi_cipo", rx_bytes[k], 8'h00);
        end
    endtask

    task automatic check_chip_id();
        int k;
        errors_at_start = error_count;
        tx_bytes.delete();
        tx_bytes.push_back(`SPI_OP_CHIP_ID);
        for (k = 0; k < 3; k++) begin
            tx_bytes.push_back(8'(random_below(256)));
        end
        run_transaction(0);
        check_value("spi_cipo", rx_bytes[0], 8'h00);
        for (k = 1; k < 4; k++) begin
            check_value("spi_cipo", rx_bytes[k], `SPI_CHIP_ID);
        end
        close_test("chip ID read");
    endtask

    task automatic unknown_opcodes();
        logic [7:0] op;
        int         n;
        int         k;
        int         operand_bytes;
        errors_at_start = error_count;
        for (n = 0; n < 3; n++) begin
            do begin
                op = 8'(random_below(256));
            end while (op == `SPI_OP_CHIP_ID || op == `SPI_OP_REG_WRITE || op == `SPI_OP_REG_READ);
            tx_bytes.delete();
            tx_bytes.push_back(op);
            operand_bytes = 1 + random_below(8);
            for (k = 0; k < operand_bytes; k++) begin
                tx_bytes.push_back(8'(random_below(256)));
            end
            run_transaction(0);
            for (k = 0; k < rx_bytes.size(); k++) begin
                check_value("spi_cipo", rx_bytes[k], 8'h00);
            end
        end
        read_and_compare(0, `SPI_REG_COUNT);
        close_test("unknown opcodes ignored");
    endtask

    initial begin
        int n;
        local_reset_n = 1'b0;
        spi_select    = 1'b1;
        spi_clock     = 1'b0;
        spi_copi      = 1'b0;
        error_count   = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        for (n = 0; n < `SPI_REG_COUNT; n++) begin
            model_regs[wrap_address(n)] = 8'h00;
        end
        wait_cycles(16);
        local_reset_n = 1'b1;
        wait_cycles(4);

        errors_at_start = error_count;
        read_and_compare(0, `SPI_REG_COUNT);
        close_test("registers zero after reset");

        check_chip_id();

        errors_at_start = error_count;
        for (n = 0; n < 8; n++) begin
            write_and_compare(random_below(`SPI_REG_COUNT), 1 + random_below(8), 0);
        end
        close_test("random burst writes");

        errors_at_start = error_count;
        for (n = 0; n < 8; n++) begin
            read_and_compare(random_below(`SPI_REG_COUNT), 1 + random_below(8));
        end
        read_and_compare(0, `SPI_REG_COUNT);
        close_test("random burst reads");

        unknown_opcodes();

        // Bits 1 to 6 of a byte only, so the cut byte never completes
        errors_at_start = error_count;
        write_and_compare(random_below(`SPI_REG_COUNT), 1 + random_below(4), 1 + random_below(6));
        read_and_compare(0, `SPI_REG_COUNT);
        close_test("interrupted write");

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+common
common/spi_pkg.sv
spi/spi_peripheral.sv
source/command_decoder.sv
source/register_bank.sv
source/spi_subsystem.sv
verification/spi_subsystem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the SPI subsystem testbench with Verilator and runs it

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module spi_subsystem_tb \
    -Mdir obj_dir

output="$(./obj_dir/Vspi_subsystem_tb)"
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
